// File: files.f
vec_pkg.sv
operand_fetch.sv
int_lane.sv
lane_writeback.sv
vector_core.sv
vector_core_properties.sv
tb_clock_gen.sv
tb_vector_core.sv

// File: Bender.yml
package:
  name: vector_core

sources:
  - vec_pkg.sv
  - operand_fetch.sv
  - int_lane.sv
  - lane_writeback.sv
  - vector_core.sv
  - target: simulation
    files:
      - vector_core_properties.sv
      - tb_clock_gen.sv
      - tb_vector_core.sv

// File: tb_vector_core.sv
////////////////////////////////////////////////////
// Vector core testbench
// Directed and random instructions against a model
////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_vector_core;
    import vec_pkg::*;

    localparam int reset_cycles   = 8;
    localparam int num_random     = 300;
    localparam int max_gap        = 3;    // Idle cycles before a random instruction
    localparam int directed_slots = 100;  // Directed tests and drains, rounded up
    localparam int cycle_limit    = reset_cycles + directed_slots
                                    + num_random * (1 + max_gap) + 20;

    typedef struct {
        int         sample_edge;  // Edge at which the DUT took it
        reg_idx_t   dest;
        lane_mask_t mask;
        vector_t    value;        // Expected ALU output, all lanes
    } pending_t;

    logic         clk;
    logic         arst_n;
    logic         instruction_valid;
    instruction_t instruction;
    logic         result_valid;
    vector_t      result;
    lane_mask_t   result_mask;
    reg_idx_t     result_reg;

    vector_t      model_rf [num_regs];  // Register file model
    pending_t     pending [$];          // Sampled, not yet written back
    logic [15:0]  lfsr_state;
    int           edge_no;
    int           cycle_count;

    tb_clock_gen u_clock_gen (.clk(clk));

    vector_core uut (.*);

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v          = {v[30:0], lfsr_state[15]};  // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic scalar_t model_alu(input logic [3:0] code, input scalar_t a,
                                          input scalar_t b);
        case (code)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_shl:  return a << b[4:0];
            op_shr:  return a >> b[4:0];
            op_seq:  return (a == b) ? 32'd1 : 32'd0;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    function automatic instruction_t make_r(input logic [3:0] op, input reg_idx_t dest,
                                            input reg_idx_t src1, input reg_idx_t src2,
                                            input lane_mask_t mask);
        instruction_t inst;
        inst        = '0;
        inst.r.op   = alu_op_t'(op);
        inst.r.dest = dest;
        inst.r.src1 = src1;
        inst.r.src2 = src2;
        inst.r.mask = mask;
        return inst;
    endfunction

    function automatic instruction_t make_i(input logic [3:0] op, input reg_idx_t dest,
                                            input reg_idx_t src1, input int imm,
                                            input lane_mask_t mask);
        instruction_t inst;
        inst          = '0;
        inst.i.op     = alu_op_t'(op);
        inst.i.is_imm = 1'b1;
        inst.i.dest   = dest;
        inst.i.src1   = src1;
        inst.i.mask   = mask;
        inst.i.imm    = imm[13:0];  // Low 14 bits, sign in bit 13
        return inst;
    endfunction

    task automatic fail_run();
        $display("=== FAIL ===");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_vector(input string name, input vector_t got, input vector_t exp,
                                input lane_mask_t lanes);
        int bad;
        bad = -1;
        for (int i = 0; i < num_lanes; i++) begin
            if (bad < 0 && lanes[i] && got[i] !== exp[i]) begin
                bad = i;  // First wrong enabled lane
            end
        end
        if (bad >= 0) begin
            $display("** Error at %0t: %s[%0d] = %h, expected %h",
                     $time, name, bad, got[bad], exp[bad]);
            fail_run();
        end
    endtask

    task automatic check_mask(input string name, input lane_mask_t got, input lane_mask_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    // Outputs sampled mid-cycle, result due two edges after sampling
    task automatic check_outputs();
        logic expect_pulse;
        expect_pulse = pending.size() > 0 && pending[0].sample_edge + 2 == edge_no;
        if (expect_pulse && result_valid !== 1'b1) begin
            $display("No result_valid pulse for the instruction writing r%0d", pending[0].dest);
            fail_run();
        end else if (!expect_pulse && result_valid !== 1'b0) begin
            $display("result_valid pulsed although no instruction was due");
            fail_run();
        end else if (expect_pulse) begin
            check_reg("result_reg", result_reg, pending[0].dest);
            check_mask("result_mask", result_mask, pending[0].mask);
            check_vector("result", result, pending[0].value, pending[0].mask);
        end
    endtask

    // Reads at this edge see the register file before this edge's write
    task automatic model_edge();
        pending_t   e;
        logic       take;
        lane_mask_t mask;
        scalar_t    imm_ext;
        vector_t    op1;
        vector_t    op2;
        edge_no++;
        mask = instruction.r.mask;  // Same field position in both forms
        take = instruction_valid && mask != '0;  // Empty mask retires nothing
        if (take) begin
            imm_ext       = {{18{instruction.i.imm[13]}}, instruction.i.imm};
            op1           = model_rf[instruction.r.src1];
            op2           = model_rf[instruction.r.src2];
            e.sample_edge = edge_no;
            e.dest        = instruction.r.dest;
            e.mask        = mask;
            for (int i = 0; i < num_lanes; i++) begin
                e.value[i] = model_alu(instruction.r.op, op1[i],
                                       instruction.r.is_imm ? imm_ext : op2[i]);
            end
        end
        if (pending.size() > 0 && pending[0].sample_edge + 3 == edge_no) begin
            for (int i = 0; i < num_lanes; i++) begin
                if (pending[0].mask[i]) begin
                    model_rf[pending[0].dest][i] = pending[0].value[i];
                end
            end
            void'(pending.pop_front());
        end
        if (take) begin
            pending.push_back(e);
        end
    endtask

    // Entered 2 ns after a rising edge, left at the same point one cycle on
    task automatic run_cycle(input logic valid, input instruction_t inst);
        instruction_valid = valid;
        instruction       = inst;
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        model_edge();
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) run_cycle(1'b0, '0);
    endtask

    task automatic drain();
        while (pending.size() > 0) begin
            run_cycle(1'b0, '0);
        end
    endtask

    task automatic test_reset();
        for (int r = 0; r < num_regs; r++) begin
            run_cycle(1'b1, make_i(op_or, reg_idx_t'(r), reg_idx_t'(r), 0, 4'hF));
        end
        drain();
    endtask

    task automatic test_immediate();
        int imms [4] = '{7, -3, 33, -8192};
        run_cycle(1'b1, make_i(op_add, 3'd1, 3'd0, -5, 4'hF));    // r1 = -5
        run_cycle(1'b1, make_i(op_add, 3'd2, 3'd0, 1234, 4'hF));  // r2 = 1234
        run_cycle(1'b1, make_i(op_sub, 3'd3, 3'd0, 1, 4'hF));     // r3 = -1
        idle(3);
        for (int c = 0; c < 16; c++) begin
            run_cycle(1'b1, make_i(4'(c), 3'd7, reg_idx_t'(1 + c % 3), imms[c % 4], 4'hF));
        end
        drain();
    endtask

    task automatic test_register();
        reg_idx_t s1;
        reg_idx_t s2;
        for (int c = 0; c < 16; c++) begin
            s1 = reg_idx_t'(3 - c % 3);           // Pairs (3,1) (2,1) (1,2)
            s2 = (c % 3 == 2) ? 3'd2 : 3'd1;      // op_slt gets -5 against 1234
            run_cycle(1'b1, make_r(4'(c), 3'd6, s1, s2, 4'hF));
        end
        drain();
    endtask

    task automatic test_masked();
        run_cycle(1'b1, make_i(op_add, 3'd5, 3'd0, 100, 4'hF));
        idle(3);
        run_cycle(1'b1, make_i(op_add, 3'd5, 3'd5, 1, 4'b0101));  // Lanes 0 and 2 only
        idle(3);
        run_cycle(1'b1, make_i(op_or, 3'd7, 3'd5, 0, 4'hF));
        run_cycle(1'b1, make_i(op_add, 3'd5, 3'd5, 999, 4'h0));   // No pulse, no write
        idle(3);
        run_cycle(1'b1, make_i(op_or, 3'd7, 3'd5, 0, 4'hF));
        drain();
    endtask

    task automatic test_write_timing();
        run_cycle(1'b1, make_i(op_add, 3'd4, 3'd0, 50, 4'hF));
        for (int n = 0; n < 5; n++) begin
            run_cycle(1'b1, make_r(op_or, 3'd7, 3'd4, 3'd0, 4'hF));  // Old value for three
        end
        drain();
    endtask

    task automatic test_random();
        logic [3:0]   op;
        logic         is_imm;
        reg_idx_t     dest;
        reg_idx_t     src1;
        reg_idx_t     src2;
        int           imm;
        instruction_t inst;
        for (int n = 0; n < num_random; n++) begin
            idle(int'(take_bits(2)));
            op     = 4'(take_bits(4));
            is_imm = 1'(take_bits(1));
            dest   = reg_idx_t'(take_bits(3));
            src1   = reg_idx_t'(take_bits(3));
            if (is_imm) begin
                imm  = int'(take_bits(14));
                inst = make_i(op, dest, src1, imm, lane_mask_t'(take_bits(4)));
            end else begin
                src2 = reg_idx_t'(take_bits(3));
                inst = make_r(op, dest, src1, src2, lane_mask_t'(take_bits(4)));
            end
            run_cycle(1'b1, inst);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run exceeded its limit of %0d cycles", cycle_limit);
            fail_run();
        end
    end

    initial begin
        lfsr_state        = 16'd96;
        edge_no           = 0;
        cycle_count       = 0;
        arst_n            = 1'b0;
        instruction_valid = 1'b0;
        instruction       = '0;
        for (int r = 0; r < num_regs; r++) begin
            model_rf[r] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_reset();
        test_immediate();
        test_register();
        test_masked();
        test_write_timing();
        test_random();
        drain();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
////////////////////////////////////////////////////
// Testbench clock source, 20 ns period
////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk
);
    localparam int half_period = 10;  // ns

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

// File: vector_core_properties.sv
////////////////////////////////////////////////////
// Vector core timing properties, bound to the top
////////////////////////////////////////////////////
`timescale 1ns/10ps

module vector_core_properties (
    input                          clk,
    input                          arst_n,
    input                          instruction_valid,
    input  vec_pkg::instruction_t  instruction,
    input                          result_valid,
    input  vec_pkg::reg_idx_t      result_reg
);
    logic issued;  // Instruction that will retire

    assign issued = instruction_valid && (instruction.r.mask != '0);  // Mask shared by both views

    assert property (@(posedge clk) !arst_n |-> !result_valid)
        else $error("result_valid high during reset");

    // Two-cycle latency, pulse seen at the third sampling edge
    assert property (@(posedge clk) disable iff (!arst_n) issued |-> ##3 result_valid)
        else $error("result_valid missing after an issued instruction");

    assert property (@(posedge clk) disable iff (!arst_n) result_valid |-> $past(issued, 3))
        else $error("result_valid without an issued instruction");

    assert property (@(posedge clk) disable iff (!arst_n) result_valid |-> !$isunknown(result_reg))
        else $error("result_reg unknown while result_valid");

endmodule

bind vector_core vector_core_properties u_properties (
    .clk               (clk),
    .arst_n            (arst_n),
    .instruction_valid (instruction_valid),
    .instruction       (instruction),
    .result_valid      (result_valid),
    .result_reg        (result_reg)
);

// File: vector_core.sv
////////////////////////////////////////////////////
// Vector integer core top level
// Operand fetch, per-lane ALUs and writeback
////////////////////////////////////////////////////
`timescale 1ns/10ps

module vector_core (
    input                          clk,
    input                          arst_n,
    input                          instruction_valid,
    input  vec_pkg::instruction_t  instruction,
    output logic                   result_valid,   // Two cycles after issue
    output vec_pkg::vector_t       result,
    output vec_pkg::lane_mask_t    result_mask,
    output vec_pkg::reg_idx_t      result_reg
);
    import vec_pkg::*;

    logic       of_valid;     // Operand fetch to writeback
    alu_op_t    of_op;        // Shared by all lanes
    reg_idx_t   of_dest;
    lane_mask_t of_mask;
    vector_t    of_operand1;
    vector_t    of_operand2;
    vector_t    lane_result;  // Lane i drives element i
    logic       wb_en;        // Writeback to the register file
    reg_idx_t   wb_reg;
    lane_mask_t wb_mask;
    vector_t    wb_value;

    operand_fetch u_operand_fetch (.*);

    // One ALU per lane
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        int_lane u_int_lane (
            .clk      (clk),
            .arst_n   (arst_n),
            .op       (of_op),
            .operand1 (of_operand1[i]),
            .operand2 (of_operand2[i]),
            .result   (lane_result[i])
        );
    end

    lane_writeback u_lane_writeback (
        .lane_results (lane_result),
        .*
    );

endmodule

// File: lane_writeback.sv
////////////////////////////////////////////////////
// Lane writeback
// Lines up control with lane results, drives the
// result outputs and the register file write
////////////////////////////////////////////////////
`timescale 1ns/10ps

module lane_writeback (
    input                          clk,
    input                          arst_n,
    input                          of_valid,
    input  vec_pkg::reg_idx_t      of_dest,
    input  vec_pkg::lane_mask_t    of_mask,
    input  vec_pkg::vector_t       lane_results,  // Gathered lane outputs
    output logic                   result_valid,
    output vec_pkg::vector_t       result,
    output vec_pkg::lane_mask_t    result_mask,
    output vec_pkg::reg_idx_t      result_reg,
    output logic                   wb_en,
    output vec_pkg::reg_idx_t      wb_reg,
    output vec_pkg::lane_mask_t    wb_mask,
    output vec_pkg::vector_t       wb_value
);
    import vec_pkg::*;

    logic       ex_valid;  // Control during the ALU stage
    reg_idx_t   ex_dest;
    lane_mask_t ex_mask;

    // Delay control by the lane ALU latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            ex_dest  <= '0;
            ex_mask  <= '0;
        end else begin
            ex_valid <= of_valid;
            ex_dest  <= of_dest;
            ex_mask  <= of_mask;
        end
    end

    // Result registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
            result_mask  <= '0;
            result_reg   <= '0;
        end else begin
            result_valid <= ex_valid;      // One-cycle pulse per instruction
            result       <= lane_results;  // Every lane, enabled or not
            result_mask  <= ex_mask;
            result_reg   <= ex_dest;
        end
    end

    // Register file write, taken by operand fetch at the next edge
    assign wb_en    = result_valid;
    assign wb_reg   = result_reg;
    assign wb_mask  = result_mask;  // Lanes outside the mask stay untouched
    assign wb_value = result;

endmodule

// File: int_lane.sv
////////////////////////////////////////////////////
// Single lane integer ALU, result registered
////////////////////////////////////////////////////
`timescale 1ns/10ps

module int_lane (
    input                       clk,
    input                       arst_n,
    input  vec_pkg::alu_op_t    op,
    input  vec_pkg::scalar_t    operand1,
    input  vec_pkg::scalar_t    operand2,
    output vec_pkg::scalar_t    result
);
    import vec_pkg::*;

    scalar_t    alu_out;   // Combinational ALU value
    logic [4:0] shamt;     // Shift amount
    logic       is_equal;
    logic       is_less;   // Signed compare

    assign shamt    = operand2[4:0];
    assign is_equal = operand1 == operand2;
    assign is_less  = $signed(operand1) < $signed(operand2);

    always_comb begin
        case (op)
            op_add:  alu_out = operand1 + operand2;
            op_sub:  alu_out = operand1 - operand2;
            op_and:  alu_out = operand1 & operand2;
            op_or:   alu_out = operand1 | operand2;
            op_xor:  alu_out = operand1 ^ operand2;
            op_shl:  alu_out = operand1 << shamt;
            op_shr:  alu_out = operand1 >> shamt;  // Zero fill
            op_seq:  alu_out = scalar_t'(is_equal);
            op_slt:  alu_out = scalar_t'(is_less);
            default: alu_out = '0;                 // Unassigned codes
        endcase
    end

    // Registered every cycle, validity rides with writeback control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else begin
            result <= alu_out;
        end
    end

endmodule

// File: operand_fetch.sv
////////////////////////////////////////////////////
// Operand fetch stage
// Decodes the instruction word, reads the vector
// register file and registers operands and control
////////////////////////////////////////////////////
`timescale 1ns/10ps

module operand_fetch (
    input                          clk,
    input                          arst_n,
    input                          instruction_valid,  // One-cycle strobe
    input  vec_pkg::instruction_t  instruction,
    input                          wb_en,              // Write from writeback
    input  vec_pkg::reg_idx_t      wb_reg,
    input  vec_pkg::lane_mask_t    wb_mask,
    input  vec_pkg::vector_t       wb_value,
    output logic                   of_valid,
    output vec_pkg::alu_op_t       of_op,
    output vec_pkg::reg_idx_t      of_dest,
    output vec_pkg::lane_mask_t    of_mask,
    output vec_pkg::vector_t       of_operand1,
    output vec_pkg::vector_t       of_operand2
);
    import vec_pkg::*;

    vector_t    reg_file [num_regs];  // Vector register file
    logic       is_imm;               // Selects the union view
    lane_mask_t inst_mask;
    scalar_t    imm_ext;              // Sign-extended immediate
    vector_t    read1;
    vector_t    read2;

    // Decode
    assign is_imm    = instruction.r.is_imm;  // Same bit in both views
    assign inst_mask = instruction.r.mask;    // Same place in both views
    assign imm_ext   = {{(scalar_width - imm_width){instruction.i.imm[imm_width-1]}},
                        instruction.i.imm};

    // Combinational reads, no bypass from writeback
    assign read1 = reg_file[instruction.r.src1];
    assign read2 = is_imm ? {num_lanes{imm_ext}}       // Broadcast immediate
                          : reg_file[instruction.r.src2];

    // Register file write, one lane at a time under wb_mask
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < num_regs; r++) begin
                reg_file[r] <= '0;  // All registers read zero
            end
        end else if (wb_en) begin
            for (int lane = 0; lane < num_lanes; lane++) begin
                if (wb_mask[lane]) begin
                    reg_file[wb_reg][lane] <= wb_value[lane];  // Disabled lanes keep value
                end
            end
        end
    end

    // Stage register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            of_valid    <= 1'b0;
            of_op       <= op_add;
            of_dest     <= '0;
            of_mask     <= '0;
            of_operand1 <= '0;
            of_operand2 <= '0;
        end else begin
            of_valid    <= instruction_valid && (inst_mask != '0);  // Empty mask retires nothing
            of_op       <= instruction.r.op;
            of_dest     <= instruction.r.dest;
            of_mask     <= instruction_valid ? inst_mask : '0;  // No lanes when idle
            of_operand1 <= read1;
            of_operand2 <= read2;
        end
    end

endmodule

// File: vec_pkg.sv
////////////////////////////////////////////////////
// Vector integer core shared definitions
// Widths, ALU opcodes and the two instruction views
////////////////////////////////////////////////////
package vec_pkg;

    localparam int num_lanes     = 4;                 // Vector lanes
    localparam int num_regs      = 8;                 // Vector registers
    localparam int scalar_width  = 32;                // Bits per lane word
    localparam int reg_idx_width = $clog2(num_regs);  // Register number width
    localparam int imm_width     = 14;                // Immediate field width

    typedef logic [scalar_width-1:0] scalar_t;        // One lane word
    typedef scalar_t [num_lanes-1:0] vector_t;        // Lane 0 in the low word
    typedef logic [num_lanes-1:0] lane_mask_t;        // Bit i enables lane i
    typedef logic [reg_idx_width-1:0] reg_idx_t;

    // Per-lane integer ALU operations
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_shl = 4'd5,    // Logical left, low 5 bits of operand 2
        op_shr = 4'd6,    // Logical right, low 5 bits of operand 2
        op_seq = 4'd7,    // 1 when equal
        op_slt = 4'd8     // 1 when signed less than
    } alu_op_t;           // Codes 9 to 15 give zero

    // Register form, both sources from the register file
    typedef struct packed {
        alu_op_t    op;       // [31:28]
        logic       is_imm;   // [27] Zero in this view
        reg_idx_t   dest;     // [26:24]
        reg_idx_t   src1;     // [23:21]
        reg_idx_t   src2;     // [20:18]
        lane_mask_t mask;     // [17:14]
        logic [13:0] unused;  // [13:0]
    } r_format_t;

    // Immediate form, second operand broadcast to all lanes
    typedef struct packed {
        alu_op_t    op;       // [31:28]
        logic       is_imm;   // [27] One in this view
        reg_idx_t   dest;     // [26:24]
        reg_idx_t   src1;     // [23:21]
        logic [2:0] unused;   // [20:18] Where src2 sits in the register form
        lane_mask_t mask;     // [17:14] Same place as in the register form
        logic [imm_width-1:0] imm;  // [13:0] Sign-extended to a lane word
    } i_format_t;

    // One instruction word, is_imm picks the view
    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instruction_t;

endpackage
